/* hw/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath widths
`define WORD_W      32
`define REG_IDX_W   5
`define OPC_W       5
`define IMM_W       17
`define ALU_W       5
`define SHAMT_W     5

// Opcodes of the kept instructions
`define OPC_RTYPE   5'd0
`define OPC_ADDI    5'd5
`define OPC_SW      5'd7
`define OPC_LW      5'd8

// Instruction field positions
`define OPC_HI      31
`define OPC_LO      27
`define RD_HI       26
`define RD_LO       22
`define RS_HI       21
`define RS_LO       17
`define RT_HI       16
`define RT_LO       12
`define SHAMT_HI    11
`define SHAMT_LO    7
`define ALUF_HI     6
`define ALUF_LO     2

`endif

/* hw/cpu_pkg.sv */
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`SHAMT_W-1:0]   shamt_t;

    // Same encoding as the R-type function field
    typedef enum logic [`ALU_W-1:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    // All flags low means a bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        alu_op_e alu_op;
    } ctrl_t;

    // rs and rt hold the register file read indices and stay zero for an unused source
    typedef struct packed {
        word_t    pc;
        ctrl_t    ctrl;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        shamt_t   shamt;
        word_t    imm;
        word_t    op_a;
        word_t    op_b;
    } dx_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
    } xm_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    load_data;
    } mw_t;

    typedef struct packed {
        reg_idx_t read_a;
        reg_idx_t read_b;
    } rf_read_t;

    typedef struct packed {
        logic     enable;
        reg_idx_t index;
        word_t    data;
    } rf_write_t;

    typedef struct packed {
        word_t address;
        word_t data;
        logic  wren;
    } dmem_req_t;

endpackage

/* hw/dx_latch.sv */
module dx_latch (
    input  logic         clock,
    input  logic         reset,
    input  cpu_pkg::dx_t decoded,
    output cpu_pkg::dx_t dx,
    output logic         stall
);
    import cpu_pkg::*;

    logic load_in_ex;
    logic hit_rs;
    logic hit_rt;

    // Load in execute whose result the decoding instruction needs next cycle
    assign load_in_ex = dx.ctrl.mem_read && (dx.rd != '0);
    assign hit_rs     = (decoded.rs == dx.rd);
    assign hit_rt     = (decoded.rt == dx.rd);
    assign stall      = load_in_ex && (hit_rs || hit_rt);

    always_ff @(posedge clock) begin
        dx <= decoded;
        // Bubble on reset and on a load-use stall
        if (reset || stall) begin
            dx.ctrl <= '0;
        end
    end

    // The bubble clears the hazard, so a stall lasts one cycle
    assert property (@(posedge clock) disable iff (reset)
        stall |=> !stall);

    // Fetch holds the stalled instruction, which enters one cycle after the bubble
    assert property (@(posedge clock) disable iff (reset)
        $past(stall, 2) |-> (dx.pc == $past(decoded.pc, 2)));

endmodule

/* hw/execute_stage.sv */
module execute_stage (
    input  logic         clock,
    input  logic         reset,
    input  cpu_pkg::dx_t dx,
    input  cpu_pkg::mw_t mw,
    output cpu_pkg::xm_t xm
);
    import cpu_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t alu_result;
    xm_t   xm_next;

    // Memory stage wins over writeback and register 0 never forwards
    function automatic word_t forward(
        input reg_idx_t src,
        input word_t    latched,
        input xm_t      mem_stage,
        input mw_t      wb_stage
    );
        word_t value;
        if (src != '0 && mem_stage.ctrl.reg_write && !mem_stage.ctrl.mem_read
                && mem_stage.rd == src) begin
            value = mem_stage.alu_result;
        end else if (src != '0 && wb_stage.ctrl.reg_write && wb_stage.rd == src) begin
            value = wb_stage.ctrl.mem_read ? wb_stage.load_data : wb_stage.alu_result;
        end else begin
            value = latched;
        end
        return value;
    endfunction

    always_comb begin
        src_a = forward(dx.rs, dx.op_a, xm, mw);
        src_b = forward(dx.rt, dx.op_b, xm, mw);
    end

    // addi, lw and sw add the immediate
    assign alu_b = dx.ctrl.use_imm ? dx.imm : src_b;

    always_comb begin
        case (dx.ctrl.alu_op)
            ALU_ADD: alu_result = src_a + alu_b;
            ALU_SUB: alu_result = src_a - alu_b;
            ALU_AND: alu_result = src_a & alu_b;
            ALU_OR:  alu_result = src_a | alu_b;
            ALU_SLL: alu_result = src_a << dx.shamt;
            ALU_SRA: alu_result = word_t'($signed(src_a) >>> dx.shamt);
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        xm_next.ctrl       = dx.ctrl;
        xm_next.rd         = dx.rd;
        xm_next.alu_result = alu_result;
        xm_next.store_data = src_b;
    end

    always_ff @(posedge clock) begin
        xm <= xm_next;
        if (reset) begin
            xm.ctrl <= '0;
        end
    end

    // Decode only enables a write for a known ALU operation
    assert property (@(posedge clock) disable iff (reset)
        dx.ctrl.reg_write |-> dx.ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND,
                                                     ALU_OR, ALU_SLL, ALU_SRA});

endmodule

/* hw/fetch_decode.sv */
`include "cpu_defines.svh"

module fetch_decode (
    input  logic              clock,
    input  logic              reset,
    input  logic              stall,
    input  cpu_pkg::word_t    q_imem,
    input  cpu_pkg::word_t    data_read_a,
    input  cpu_pkg::word_t    data_read_b,
    output cpu_pkg::word_t    address_imem,
    output cpu_pkg::rf_read_t rf_read,
    output cpu_pkg::dx_t      decoded
);
    import cpu_pkg::*;

    word_t             pc;
    word_t             fd_pc;
    word_t             fd_insn;
    logic              fd_valid;
    logic [`OPC_W-1:0] opcode;
    logic [`ALU_W-1:0] alu_field;
    reg_idx_t          rd_field;
    reg_idx_t          rs_field;
    reg_idx_t          rt_field;
    ctrl_t             ctrl;
    reg_idx_t          idx_a;
    reg_idx_t          idx_b;

    // PC counts in words and holds during a load-use stall
    always_ff @(posedge clock) begin
        if (reset) begin
            pc       <= '0;
            fd_valid <= 1'b0;
        end else if (!stall) begin
            pc       <= pc + 1'b1;
            fd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_insn <= q_imem;
            fd_pc   <= pc;
        end
    end

    assign address_imem = pc;

    assign opcode    = fd_insn[`OPC_HI:`OPC_LO];
    assign alu_field = fd_insn[`ALUF_HI:`ALUF_LO];
    assign rd_field  = fd_insn[`RD_HI:`RD_LO];
    assign rs_field  = fd_insn[`RS_HI:`RS_LO];
    assign rt_field  = fd_insn[`RT_HI:`RT_LO];

    // Anything outside the kept set decodes as a no-op
    always_comb begin
        ctrl  = '0;
        idx_a = '0;
        idx_b = '0;
        if (fd_valid) begin
            case (opcode)
                `OPC_RTYPE: begin
                    if (alu_field inside {ALU_ADD, ALU_SUB, ALU_AND,
                                          ALU_OR, ALU_SLL, ALU_SRA}) begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_op_e'(alu_field);
                        idx_a          = rs_field;
                        idx_b          = rt_field;
                    end
                end
                `OPC_ADDI: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    idx_a          = rs_field;
                end
                `OPC_LW: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    idx_a          = rs_field;
                end
                `OPC_SW: begin
                    ctrl.mem_write = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    idx_a          = rs_field;
                    // Store data comes from the rd field
                    idx_b          = rd_field;
                end
                default: ;
            endcase
        end
    end

    assign rf_read.read_a = idx_a;
    assign rf_read.read_b = idx_b;

    always_comb begin
        decoded.pc    = fd_pc;
        decoded.ctrl  = ctrl;
        decoded.rd    = rd_field;
        decoded.rs    = idx_a;
        decoded.rt    = idx_b;
        decoded.shamt = fd_insn[`SHAMT_HI:`SHAMT_LO];
        decoded.imm   = {{(`WORD_W - `IMM_W){fd_insn[`IMM_W-1]}}, fd_insn[`IMM_W-1:0]};
        // r0 always reads as zero
        decoded.op_a  = (idx_a == '0) ? '0 : data_read_a;
        decoded.op_b  = (idx_b == '0) ? '0 : data_read_b;
    end

endmodule

/* hw/mem_writeback.sv */
module mem_writeback (
    input  logic               clock,
    input  logic               reset,
    input  cpu_pkg::xm_t       xm,
    input  cpu_pkg::word_t     q_dmem,
    output cpu_pkg::dmem_req_t dmem_req,
    output cpu_pkg::mw_t       mw,
    output cpu_pkg::rf_write_t rf_write
);
    import cpu_pkg::*;

    mw_t mw_next;

    // Data memory answers in the same cycle
    always_comb begin
        dmem_req.address = xm.alu_result;
        dmem_req.data    = xm.store_data;
        dmem_req.wren    = xm.ctrl.mem_write;
    end

    always_comb begin
        mw_next.ctrl       = xm.ctrl;
        mw_next.rd         = xm.rd;
        mw_next.alu_result = xm.alu_result;
        mw_next.load_data  = q_dmem;
    end

    always_ff @(posedge clock) begin
        mw <= mw_next;
        if (reset) begin
            mw.ctrl <= '0;
        end
    end

    // Writes to r0 are dropped here
    always_comb begin
        rf_write.enable = mw.ctrl.reg_write && (mw.rd != '0);
        rf_write.index  = mw.rd;
        rf_write.data   = mw.ctrl.mem_read ? mw.load_data : mw.alu_result;
    end

    // Register 0 is never a write target
    assert property (@(posedge clock) disable iff (reset)
        rf_write.enable |-> (rf_write.index != '0));

endmodule

/* hw/processor.sv */
module processor (
    input  logic               clock,
    input  logic               reset,
    output cpu_pkg::word_t     address_imem,
    input  cpu_pkg::word_t     q_imem,
    output cpu_pkg::dmem_req_t dmem_req,
    input  cpu_pkg::word_t     q_dmem,
    output cpu_pkg::rf_read_t  rf_read,
    input  cpu_pkg::word_t     data_read_a,
    input  cpu_pkg::word_t     data_read_b,
    output cpu_pkg::rf_write_t rf_write
);
    import cpu_pkg::*;

    dx_t  decoded;
    dx_t  dx;
    xm_t  xm;
    mw_t  mw;
    logic stall;

    fetch_decode fetch_decode_inst (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .q_imem       (q_imem),
        .data_read_a  (data_read_a),
        .data_read_b  (data_read_b),
        .address_imem (address_imem),
        .rf_read      (rf_read),
        .decoded      (decoded)
    );

    dx_latch dx_latch_inst (
        .clock   (clock),
        .reset   (reset),
        .decoded (decoded),
        .dx      (dx),
        .stall   (stall)
    );

    execute_stage execute_stage_inst (
        .clock (clock),
        .reset (reset),
        .dx    (dx),
        .mw    (mw),
        .xm    (xm)
    );

    mem_writeback mem_writeback_inst (
        .clock    (clock),
        .reset    (reset),
        .xm       (xm),
        .q_dmem   (q_dmem),
        .dmem_req (dmem_req),
        .mw       (mw),
        .rf_write (rf_write)
    );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_processor -f tb.f -o tb_processor_sim

out=$(./obj_dir/tb_processor_sim)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"

/* sim/tb_clock.sv */
module tb_clock (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Power-on reset over the first five rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

/* sim/tb_processor.sv */
`include "cpu_defines.svh"

module tb_processor;
    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRAIN_CYCLES   = 8;
    localparam int POR_TIMEOUT    = 20;

    logic      clock;
    logic      por_reset;
    logic      test_reset;
    logic      reset;
    logic      mem_init;
    word_t     address_imem;
    word_t     q_imem;
    dmem_req_t dmem_req;
    word_t     q_dmem;
    rf_read_t  rf_read;
    word_t     data_read_a;
    word_t     data_read_b;
    rf_write_t rf_write;

    word_t     imem [256];
    word_t     dmem_words [256];
    word_t     rf_regs [32];
    int        prog_len;
    logic [31:0] lcg_state;

    rf_write_t exp_writes[$];
    dmem_req_t exp_stores[$];
    int        error_count;
    int        pass_count;
    int        fail_count;

    tb_clock tb_clock_inst (
        .clock (clock),
        .reset (por_reset)
    );

    assign reset = por_reset || test_reset;

    processor processor_inst (
        .clock        (clock),
        .reset        (reset),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .dmem_req     (dmem_req),
        .q_dmem       (q_dmem),
        .rf_read      (rf_read),
        .data_read_a  (data_read_a),
        .data_read_b  (data_read_b),
        .rf_write     (rf_write)
    );

    function automatic word_t fill_word(input int unsigned addr);
        return (addr * 32'h9e37_79b9) ^ 32'hc3a5_0f1e;
    endfunction

    // Register file and data memory reload while mem_init is high
    always @(posedge clock) begin
        int i;
        if (mem_init) begin
            for (i = 0; i < 256; i++) begin
                dmem_words[i] <= fill_word(i);
            end
            for (i = 0; i < 32; i++) begin
                rf_regs[i] <= '0;
            end
        end else if (!reset) begin
            if (rf_write.enable) begin
                rf_regs[rf_write.index] <= rf_write.data;
            end
            if (dmem_req.wren) begin
                dmem_words[dmem_req.address[7:0]] <= dmem_req.data;
            end
        end
    end

    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = mem_init ? '0 : dmem_words[dmem_req.address[7:0]];

    always_comb begin
        data_read_a = rf_regs[rf_read.read_a];
        data_read_b = rf_regs[rf_read.read_b];
        // A write in the same cycle is seen by the read
        if (rf_write.enable && rf_write.index == rf_read.read_a) begin
            data_read_a = rf_write.data;
        end
        if (rf_write.enable && rf_write.index == rf_read.read_b) begin
            data_read_b = rf_write.data;
        end
        if (mem_init) begin
            data_read_a = '0;
            data_read_b = '0;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'(lcg_state[31:8]) % n;
    endfunction

    function automatic word_t enc_r(input alu_op_e op, input int rd, input int rs,
                                    input int rt, input int sh);
        return {`OPC_RTYPE, rd[4:0], rs[4:0], rt[4:0], sh[4:0], op, 2'b00};
    endfunction

    function automatic word_t enc_i(input logic [`OPC_W-1:0] opc, input int rd,
                                    input int rs, input int imm);
        return {opc, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic void append(input word_t insn);
        imem[prog_len] = insn;
        prog_len++;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_index(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Sequential ISA model that predicts the ordered write and store streams
    task automatic golden_run();
        word_t     gold_regs [32];
        word_t     gold_mem [256];
        word_t     insn;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     res;
        word_t     addr;
        reg_idx_t  rd;
        logic      has_write;
        rf_write_t w;
        dmem_req_t s;
        int        i;
        exp_writes.delete();
        exp_stores.delete();
        for (i = 0; i < 32; i++) begin
            gold_regs[i] = '0;
        end
        for (i = 0; i < 256; i++) begin
            gold_mem[i] = fill_word(i);
        end
        for (i = 0; i < prog_len; i++) begin
            insn = imem[i];
            rd = insn[`RD_HI:`RD_LO];
            a = gold_regs[insn[`RS_HI:`RS_LO]];
            b = gold_regs[insn[`RT_HI:`RT_LO]];
            imm = word_t'($signed(insn[`IMM_W-1:0]));
            addr = a + imm;
            res = '0;
            has_write = 1'b0;
            case (insn[`OPC_HI:`OPC_LO])
                `OPC_RTYPE: begin
                    has_write = 1'b1;
                    case (insn[`ALUF_HI:`ALUF_LO])
                        5'd0: res = a + b;
                        5'd1: res = a - b;
                        5'd2: res = a & b;
                        5'd3: res = a | b;
                        5'd4: res = a << insn[`SHAMT_HI:`SHAMT_LO];
                        5'd5: res = $signed(a) >>> insn[`SHAMT_HI:`SHAMT_LO];
                        default: has_write = 1'b0;
                    endcase
                end
                `OPC_ADDI: begin
                    res = addr;
                    has_write = 1'b1;
                end
                `OPC_LW: begin
                    res = gold_mem[addr[7:0]];
                    has_write = 1'b1;
                end
                `OPC_SW: begin
                    gold_mem[addr[7:0]] = gold_regs[rd];
                    s.address = addr;
                    s.data = gold_regs[rd];
                    s.wren = 1'b1;
                    exp_stores.push_back(s);
                end
                default: ;
            endcase
            if (has_write && rd != '0) begin
                gold_regs[rd] = res;
                w.enable = 1'b1;
                w.index = rd;
                w.data = res;
                exp_writes.push_back(w);
            end
        end
    endtask

    task automatic start_program();
        int i;
        @(negedge clock);
        test_reset = 1'b1;
        mem_init = 1'b1;
        for (i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        prog_len = 0;
    endtask

    task automatic sample_cycle(inout int repeats, inout word_t last_addr);
        rf_write_t ew;
        dmem_req_t es;
        if (rf_write.enable) begin
            if (exp_writes.size() == 0) begin
                $display("At %0d ns an unexpected register write to r%0d appeared",
                         $time, rf_write.index);
                error_count++;
            end else begin
                ew = exp_writes.pop_front();
                check_index("rf_write.index", rf_write.index, ew.index);
                check_word("rf_write.data", rf_write.data, ew.data);
            end
        end
        if (dmem_req.wren) begin
            if (exp_stores.size() == 0) begin
                $display("At %0d ns an unexpected store to %h appeared",
                         $time, dmem_req.address);
                error_count++;
            end else begin
                es = exp_stores.pop_front();
                check_word("dmem_req.address", dmem_req.address, es.address);
                check_word("dmem_req.data", dmem_req.data, es.data);
            end
        end
        if (address_imem == last_addr) begin
            repeats++;
        end
        last_addr = address_imem;
    endtask

    // expect_repeats below zero skips the fetch address check
    task automatic run_program(input string name, input int expect_repeats);
        int    cycles;
        int    repeats;
        int    errors_before;
        word_t last_addr;
        errors_before = error_count;
        golden_run();
        repeat (2) @(negedge clock);
        test_reset = 1'b0;
        mem_init = 1'b0;
        last_addr = address_imem;
        cycles = 0;
        repeats = 0;
        while ((exp_writes.size() + exp_stores.size()) > 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
            sample_cycle(repeats, last_addr);
        end
        if ((exp_writes.size() + exp_stores.size()) > 0) begin
            $display("%s stalled for %0d cycles with %0d writes and %0d stores missing",
                     name, cycles, exp_writes.size(), exp_stores.size());
            error_count++;
        end else begin
            repeat (DRAIN_CYCLES) begin
                @(negedge clock);
                sample_cycle(repeats, last_addr);
            end
            if (expect_repeats >= 0 && repeats != expect_repeats) begin
                $display("%s: address_imem repeated %0d times instead of %0d",
                         name, repeats, expect_repeats);
                error_count++;
            end
        end
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // Each result feeds the next, so both forwarding paths get used
    task automatic test_alu_chain();
        start_program();
        append(enc_i(`OPC_ADDI, 1, 0, 1234));
        append(enc_i(`OPC_ADDI, 2, 0, -77));
        append(enc_r(ALU_ADD, 3, 1, 2, 0));
        append(enc_r(ALU_SUB, 4, 3, 1, 0));
        append(enc_r(ALU_AND, 5, 4, 3, 0));
        append(enc_r(ALU_OR, 6, 5, 4, 0));
        append(enc_r(ALU_SLL, 7, 6, 0, 5));
        append(enc_r(ALU_SRA, 8, 7, 0, 3));
        append(enc_r(ALU_ADD, 9, 8, 7, 0));
        append(enc_r(ALU_SUB, 10, 9, 8, 0));
        run_program("alu_chain", -1);
    endtask

    task automatic test_addi_imm();
        start_program();
        append(enc_i(`OPC_ADDI, 1, 0, 1));
        append(enc_i(`OPC_ADDI, 2, 1, -1));
        // Most negative 17-bit immediate
        append(enc_i(`OPC_ADDI, 3, 0, -65536));
        append(enc_i(`OPC_ADDI, 4, 3, 65535));
        append(enc_i(`OPC_ADDI, 5, 4, -2));
        run_program("addi_imm", -1);
    endtask

    task automatic test_store_load();
        start_program();
        append(enc_i(`OPC_ADDI, 1, 0, 40));
        append(enc_i(`OPC_ADDI, 2, 0, 'h1234));
        append(enc_i(`OPC_SW, 2, 1, 3));
        append(enc_i(`OPC_LW, 3, 1, 3));
        append(enc_i(`OPC_ADDI, 4, 1, -10));
        append(enc_i(`OPC_SW, 3, 4, 0));
        append(enc_i(`OPC_LW, 5, 0, 30));
        append(enc_r(ALU_ADD, 6, 5, 2, 0));
        run_program("store_load", -1);
    endtask

    // One load-use pair, so fetch holds exactly once
    task automatic test_load_use();
        start_program();
        append(enc_i(`OPC_ADDI, 1, 0, 9));
        append(enc_i(`OPC_LW, 2, 1, 0));
        append(enc_r(ALU_ADD, 3, 2, 1, 0));
        append(enc_r(ALU_ADD, 4, 3, 2, 0));
        run_program("load_use", 1);
    endtask

    task automatic test_reg_zero();
        start_program();
        append(enc_i(`OPC_ADDI, 1, 0, 7));
        append(enc_i(`OPC_ADDI, 0, 1, 5));
        append(enc_r(ALU_ADD, 2, 0, 1, 0));
        append(enc_r(ALU_OR, 0, 1, 2, 0));
        append(enc_i(`OPC_LW, 0, 0, 5));
        append(enc_r(ALU_ADD, 3, 0, 0, 0));
        append(enc_i(`OPC_SW, 0, 1, 0));
        run_program("reg_zero", -1);
    endtask

    task automatic test_random_program();
        int i;
        int kind;
        start_program();
        // Nonzero starting values in r1 to r7
        for (i = 1; i < 8; i++) begin
            append(enc_i(`OPC_ADDI, i, 0, i * 1000 - 3500));
        end
        for (i = 0; i < 40; i++) begin
            kind = rand_below(8);
            if (kind < 4) begin
                append(enc_r(alu_op_e'(rand_below(6)), rand_below(8), rand_below(8),
                             rand_below(8), rand_below(32)));
            end else if (kind < 6) begin
                append(enc_i(`OPC_ADDI, rand_below(8), rand_below(8),
                             rand_below(131072) - 65536));
            end else if (kind == 6) begin
                append(enc_i(`OPC_LW, rand_below(8), 0, rand_below(256)));
            end else begin
                append(enc_i(`OPC_SW, rand_below(8), 0, rand_below(256)));
            end
        end
        run_program("random_program", -1);
    endtask

    initial begin
        int wait_cycles;
        test_reset = 1'b0;
        mem_init = 1'b1;
        prog_len = 0;
        lcg_state = 32'h6e1f_0546;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        wait_cycles = 0;
        while (por_reset !== 1'b0 && wait_cycles < POR_TIMEOUT) begin
            @(negedge clock);
            wait_cycles++;
        end
        if (por_reset !== 1'b0) begin
            $display("Power-on reset was still high after %0d cycles", wait_cycles);
            error_count++;
        end
        test_alu_chain();
        test_addi_imm();
        test_store_load();
        test_load_use();
        test_reg_zero();
        test_random_program();
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_decode.sv
hw/dx_latch.sv
hw/execute_stage.sv
hw/mem_writeback.sv
hw/processor.sv
sim/tb_clock.sv
sim/tb_processor.sv
